// File: source/armPipe_config.svh
`ifndef ARM_PIPE_CONFIG_SVH
`define ARM_PIPE_CONFIG_SVH

// Width of every data, address and instruction word
`define WORD_WIDTH 32

// Address of the first instruction fetch after reset
`define RESET_VECTOR 32'h0000_0000

// Register count and architectural width of a register number
`define REG_ADDR_WIDTH 4

// Byte step between consecutive instructions
`define INSTR_BYTES 4

// ARM reads the PC two instructions ahead of the branch
`define PC_AHEAD 8

`endif

// File: source/armPipePkg.sv
`include "armPipe_config.svh"

package armPipePkg;

  // Data, address and instruction word
  typedef logic [`WORD_WIDTH-1:0] word_t;

  // Register number, r15 is the PC
  typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;

  // ALU operation
  typedef logic [2:0] aluCtrl_t;

  // Operand source for the execute stage
  typedef logic [1:0] forward_t;

  localparam aluCtrl_t ALU_ADD  = 3'd0;
  localparam aluCtrl_t ALU_SUB  = 3'd1;
  localparam aluCtrl_t ALU_AND  = 3'd2;
  localparam aluCtrl_t ALU_ORR  = 3'd3;
  localparam aluCtrl_t ALU_MOVB = 3'd4;

  localparam forward_t FWD_REG = 2'b00;
  localparam forward_t FWD_WB  = 2'b01;
  localparam forward_t FWD_MEM = 2'b10;

  localparam regAddr_t PC_REG = 4'hF;

endpackage

// File: source/hazard.sv
module hazard (
  input  logic                clk,
  input  logic                rstN,
  input  logic                match1EM, match1EW, match2EM, match2EW, match1DE, match2DE,
  input  logic                regWriteM, regWriteW,
  input  logic                memToRegE, branchTakenE,
  input  logic                iStall, dStall,
  output armPipePkg::forward_t forwardAE, forwardBE,
  output logic                stallF, stallD, stallE, stallM, stallW,
  output logic                flushD, flushE, flushW
);
  import armPipePkg::*;

  logic loadUseD;

  // Memory stage holds the younger result, so it wins over writeback
  always_comb
  begin
    if (match1EM && regWriteM)
      forwardAE = FWD_MEM;
    else if (match1EW && regWriteW)
      forwardAE = FWD_WB;
    else
      forwardAE = FWD_REG;

    if (match2EM && regWriteM)
      forwardBE = FWD_MEM;
    else if (match2EW && regWriteW)
      forwardBE = FWD_WB;
    else
      forwardBE = FWD_REG;
  end

  // Load in execute feeds an instruction in decode one cycle too late
  assign loadUseD = (match1DE | match2DE) & memToRegE;

  // Data wait freezes the whole pipe
  assign stallF = loadUseD | iStall | dStall;
  assign stallD = loadUseD | dStall;
  assign stallE = dStall;
  assign stallM = dStall;
  assign stallW = dStall;
  // Writeback retires once, then bubbles while memory waits
  assign flushW = dStall;

  // Branch or load bubble into execute, held back while execute is frozen
  assign flushE = (loadUseD | branchTakenE) & ~dStall;
  // Missing fetch becomes a bubble unless decode must keep its instruction
  assign flushD = (branchTakenE & ~dStall) | (iStall & ~stallD);

  // A resolved branch kills decode and leaves a bubble behind it in execute
  branchFlushChk: assert property (@(posedge clk) disable iff (!rstN)
    (branchTakenE && !dStall) |-> ((flushD && !stallD) ##1 !branchTakenE));

  // Writeback forwarding only from a writer that left memory without a wait
  fwdWriteChk: assert property (@(posedge clk) disable iff (!rstN)
    (forwardAE == FWD_WB || forwardBE == FWD_WB) |-> $past(regWriteM && !dStall));

  // Pipeline is quiet once reset has cleared the stage registers
  resetQuietChk: assert property (@(posedge clk)
    (!rstN ##1 !rstN) |-> (!(stallF || stallD || stallE || stallM || stallW ||
      flushD || flushE || flushW) && forwardAE == FWD_REG && forwardBE == FWD_REG));

endmodule

// File: source/regFile.sv
module regFile (
  input  logic                 clk,
  input  logic                 we,
  input  armPipePkg::regAddr_t ra1, ra2, wa,
  input  armPipePkg::word_t    wd,
  output armPipePkg::word_t    rd1, rd2
);
  import armPipePkg::*;

  // r0 to r14, the PC lives in the datapath
  word_t regs [0:14];

  // Falling edge write, a same-cycle read in decode sees the new value
  always_ff @(negedge clk)
  begin
    if (we && (wa != PC_REG))
    begin
      regs[wa] <= wd;
    end
  end

  // r15 reads as zero
  assign rd1 = (ra1 == PC_REG) ? '0 : regs[ra1];
  assign rd2 = (ra2 == PC_REG) ? '0 : regs[ra2];

  // Write port never targets the PC
  pcWriteChk: assert property (@(posedge clk) we |-> (wa != PC_REG));

endmodule

// File: source/decoder.sv
module decoder (
  input  armPipePkg::word_t    instrD,
  output logic                 regWriteD, memWriteD, memToRegD, branchD, aluSrcD,
  output armPipePkg::aluCtrl_t aluCtrlD,
  output armPipePkg::regAddr_t ra1D, ra2D, waD,
  output armPipePkg::word_t    immD
);
  import armPipePkg::*;

  logic     condAl, immOp, isLoad, isMov;
  logic     dpOpOk, operandOk, isDp, isMem, isBr;
  aluCtrl_t aluDp;
  regAddr_t rn, rd, rm;

  assign rn = instrD[19:16];
  assign rd = instrD[15:12];
  assign rm = instrD[3:0];
  assign immOp = instrD[25];
  assign isLoad = instrD[20];

  // Only the "always" condition is executed
  assign condAl = (instrD[31:28] == 4'b1110);

  // Data-processing opcode field
  always_comb
  begin
    dpOpOk = 1'b1;
    case (instrD[24:21])
      4'b0100: aluDp = ALU_ADD;
      4'b0010: aluDp = ALU_SUB;
      4'b0000: aluDp = ALU_AND;
      4'b1100: aluDp = ALU_ORR;
      4'b1101: aluDp = ALU_MOVB;
      default:
      begin
        aluDp = ALU_ADD;
        dpOpOk = 1'b0;
      end
    endcase
  end

  assign isMov = (instrD[24:21] == 4'b1101);
  // Immediate needs zero rotate, register needs no shift
  assign operandOk = immOp ? (instrD[11:8] == 4'b0000)
                           : ((instrD[11:4] == 8'h00) && (rm != PC_REG));

  // No PC reads or writes anywhere in the subset
  assign isDp = condAl && (instrD[27:26] == 2'b00) && dpOpOk && operandOk &&
                (rd != PC_REG) && (isMov || (rn != PC_REG));
  // Pre-indexed, add offset, word access, no writeback
  assign isMem = condAl && (instrD[27:21] == 7'b0101100) &&
                 (rd != PC_REG) && (rn != PC_REG);
  // Plain B, BL is not supported
  assign isBr = condAl && (instrD[27:24] == 4'b1010);

  assign regWriteD = isDp | (isMem & isLoad);
  assign memWriteD = isMem & ~isLoad;
  assign memToRegD = isMem & isLoad;
  assign branchD = isBr;
  assign aluSrcD = (isDp & immOp) | isMem;
  // Address is base plus offset
  assign aluCtrlD = isMem ? ALU_ADD : aluDp;

  // Store data comes through the second read port
  assign ra1D = rn;
  assign ra2D = isMem ? rd : rm;
  assign waD = rd;

  // Word offset for B, byte offset for memory, byte literal for ALU
  assign immD = isBr  ? {{6{instrD[23]}}, instrD[23:0], 2'b00} :
                isMem ? {20'h00000, instrD[11:0]} :
                        {24'h000000, instrD[7:0]};

endmodule

// File: source/datapath.sv
`include "armPipe_config.svh"

module datapath (
  input  logic                 clk,
  input  logic                 rstN,
  // Instruction bus master
  output logic                 iCyc, iStb,
  output armPipePkg::word_t    iAdr,
  input  armPipePkg::word_t    iDatI,
  input  logic                 iAck,
  // Data bus master
  output logic                 dCyc, dStb, dWe,
  output armPipePkg::word_t    dAdr, dDatO,
  input  armPipePkg::word_t    dDatI,
  input  logic                 dAck,
  // Decoder
  input  logic                 regWriteD, memWriteD, memToRegD, branchD, aluSrcD,
  input  armPipePkg::aluCtrl_t aluCtrlD,
  input  armPipePkg::regAddr_t ra1D, ra2D, waD,
  input  armPipePkg::word_t    immD,
  output armPipePkg::word_t    instrD,
  // Register file
  input  armPipePkg::word_t    rd1D, rd2D,
  output logic                 regWriteW,
  output armPipePkg::regAddr_t waW,
  output armPipePkg::word_t    resultW,
  // Hazard unit
  output logic                 match1EM, match1EW, match2EM, match2EW, match1DE, match2DE,
  output logic                 regWriteM, memToRegE, branchTakenE, iStall, dStall,
  input  armPipePkg::forward_t forwardAE, forwardBE,
  input  logic                 stallF, stallD, stallE, stallM, stallW,
  input  logic                 flushD, flushE, flushW
);
  import armPipePkg::*;

  word_t    pcF, pcD, pcE, redirTarget, branchTargetE;
  logic     redirPend, redirectE;
  logic     regWriteE, memWriteE, branchE, aluSrcE;
  aluCtrl_t aluCtrlE;
  regAddr_t ra1E, ra2E, waE, waM;
  word_t    immE, rd1E, rd2E, srcAE, srcBE, writeDataE, aluResultE;
  logic     memWriteM, memToRegM, memToRegW;
  word_t    aluResultM, writeDataM, aluResultW, readDataW;

  // Fetch
  // Instruction port requests from the first cycle after reset on
  always_ff @(posedge clk)
  begin
    if (!rstN)
      iCyc <= 1'b0;
    else
      iCyc <= 1'b1;
  end

  assign iStb = iCyc;
  assign iAdr = pcF;
  assign iStall = iCyc & ~iAck;

  // Branch leaves execute this cycle
  assign redirectE = branchTakenE & ~dStall;

  // PC must hold during a fetch wait, so a late branch is parked
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      pcF <= `RESET_VECTOR;
      redirPend <= 1'b0;
    end
    else if (!stallF && iCyc)
    begin
      if (redirectE)
        pcF <= branchTargetE;
      else if (redirPend)
        pcF <= redirTarget;
      else
        pcF <= pcF + `INSTR_BYTES;
      redirPend <= 1'b0;
    end
    else if (redirectE)
      redirPend <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (redirectE)
      redirTarget <= branchTargetE;
  end

  // Decode register
  // Wrong-path word behind a parked branch is dropped too
  always_ff @(posedge clk)
  begin
    if (!rstN || flushD || redirPend || !iCyc)
      instrD <= '0;
    else if (!stallD)
      instrD <= iDatI;
  end

  always_ff @(posedge clk)
  begin
    if (!stallD)
      pcD <= pcF;
  end

  // Execute register
  always_ff @(posedge clk)
  begin
    if (!rstN || flushE)
    begin
      regWriteE <= 1'b0;
      memWriteE <= 1'b0;
      memToRegE <= 1'b0;
      branchE <= 1'b0;
    end
    else if (!stallE)
    begin
      regWriteE <= regWriteD;
      memWriteE <= memWriteD;
      memToRegE <= memToRegD;
      branchE <= branchD;
    end
  end

  // Held operands pick up forwarded values before writeback drains
  always_ff @(posedge clk)
  begin
    if (!stallE)
    begin
      aluSrcE <= aluSrcD;
      aluCtrlE <= aluCtrlD;
      ra1E <= ra1D;
      ra2E <= ra2D;
      waE <= waD;
      immE <= immD;
      pcE <= pcD;
      rd1E <= rd1D;
      rd2E <= rd2D;
    end
    else
    begin
      rd1E <= srcAE;
      rd2E <= writeDataE;
    end
  end

  // Execute
  always_comb
  begin
    case (forwardAE)
      FWD_WB:  srcAE = resultW;
      FWD_MEM: srcAE = aluResultM;
      default: srcAE = rd1E;
    endcase
    case (forwardBE)
      FWD_WB:  writeDataE = resultW;
      FWD_MEM: writeDataE = aluResultM;
      default: writeDataE = rd2E;
    endcase
  end

  assign srcBE = aluSrcE ? immE : writeDataE;

  always_comb
  begin
    case (aluCtrlE)
      ALU_SUB:  aluResultE = srcAE - srcBE;
      ALU_AND:  aluResultE = srcAE & srcBE;
      ALU_ORR:  aluResultE = srcAE | srcBE;
      ALU_MOVB: aluResultE = srcBE;
      default:  aluResultE = srcAE + srcBE;
    endcase
  end

  // Only condition "always" exists, so every branch is taken
  assign branchTakenE = branchE;
  assign branchTargetE = pcE + `PC_AHEAD + immE;

  // Source matches against younger stages
  assign match1EM = (ra1E == waM);
  assign match1EW = (ra1E == waW);
  assign match2EM = (ra2E == waM);
  assign match2EW = (ra2E == waW);
  assign match1DE = (ra1D == waE);
  assign match2DE = (ra2D == waE);

  // Memory register
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      regWriteM <= 1'b0;
      memWriteM <= 1'b0;
      memToRegM <= 1'b0;
    end
    else if (!stallM)
    begin
      regWriteM <= regWriteE;
      memWriteM <= memWriteE;
      memToRegM <= memToRegE;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!stallM)
    begin
      aluResultM <= aluResultE;
      writeDataM <= writeDataE;
      waM <= waE;
    end
  end

  // Data bus follows the memory stage, frozen until ack
  assign dCyc = memWriteM | memToRegM;
  assign dStb = dCyc;
  assign dWe = memWriteM;
  assign dAdr = aluResultM;
  assign dDatO = writeDataM;
  assign dStall = dCyc & ~dAck;

  // Writeback register
  always_ff @(posedge clk)
  begin
    if (!rstN || flushW)
    begin
      regWriteW <= 1'b0;
      memToRegW <= 1'b0;
    end
    else if (!stallW)
    begin
      regWriteW <= regWriteM;
      memToRegW <= memToRegM;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!stallW)
    begin
      aluResultW <= aluResultM;
      readDataW <= dDatI;
      waW <= waM;
    end
  end

  assign resultW = memToRegW ? readDataW : aluResultW;

  // Wishbone masters hold the request until ack
  iHoldChk: assert property (@(posedge clk) disable iff (!rstN)
    (iCyc && !iAck) |=> (iCyc && $stable(iAdr)));

  dHoldChk: assert property (@(posedge clk) disable iff (!rstN)
    (dCyc && !dAck) |=> (dCyc && $stable(dAdr) && $stable(dWe) && $stable(dDatO)));

endmodule

// File: source/armPipeTop.sv
module armPipeTop (
  input  logic              clk,
  input  logic              rstN,
  // Instruction bus
  output logic              iCyc, iStb,
  output armPipePkg::word_t iAdr,
  input  armPipePkg::word_t iDatI,
  input  logic              iAck,
  // Data bus
  output logic              dCyc, dStb, dWe,
  output armPipePkg::word_t dAdr, dDatO,
  input  armPipePkg::word_t dDatI,
  input  logic              dAck
);
  import armPipePkg::*;

  // Decode stage controls
  word_t    instrD, immD, rd1D, rd2D;
  logic     regWriteD, memWriteD, memToRegD, branchD, aluSrcD;
  aluCtrl_t aluCtrlD;
  regAddr_t ra1D, ra2D, waD;

  // Register write from writeback
  logic     regWriteW;
  regAddr_t waW;
  word_t    resultW;

  // Hazard handshake
  logic     match1EM, match1EW, match2EM, match2EW, match1DE, match2DE;
  logic     regWriteM, memToRegE, branchTakenE, iStall, dStall;
  forward_t forwardAE, forwardBE;
  logic     stallF, stallD, stallE, stallM, stallW;
  logic     flushD, flushE, flushW;

  datapath datapathInst (.*);

  decoder decoderInst (.*);

  hazard hazardInst (.*);

  // Read in decode, write from writeback
  regFile regFileInst (
    .clk (clk),
    .we  (regWriteW),
    .ra1 (ra1D),
    .ra2 (ra2D),
    .wa  (waW),
    .wd  (resultW),
    .rd1 (rd1D),
    .rd2 (rd2D)
  );

endmodule

// File: verification/wbMemModel.sv
module wbMemModel #(
  parameter int WORDS = 256,
  parameter int SEED  = 1
) (
  input  logic              clk,
  input  logic              rstN,
  input  logic              cyc, stb, we,
  input  armPipePkg::word_t adr, datI,
  input  logic [1:0]        maxWait,
  output armPipePkg::word_t datO,
  output logic              ack
);
  import armPipePkg::*;

  localparam int IDX_BITS = $clog2(WORDS);

  word_t mem [0:WORDS-1];
  integer seed = SEED;
  int waitCnt = 0;

  // Values seen at the clock edge, applied shortly after it
  logic doWrite, gotAck, busy, inReset;
  logic [IDX_BITS-1:0] wIdx;
  word_t wData;

  // Zero-wait transfers are acked in the cycle of the request
  assign ack = rstN && cyc && stb && (waitCnt == 0);
  assign datO = rstN ? mem[adr[IDX_BITS+1:2]] : '0;

  function automatic int drawWait();
    return $unsigned($random(seed)) % (int'(maxWait) + 1);
  endfunction

  always @(posedge clk)
  begin
    inReset = !rstN;
    gotAck = ack;
    busy = cyc && stb;
    doWrite = ack && we;
    wIdx = adr[IDX_BITS+1:2];
    wData = datI;
    #1;
    if (inReset)
      waitCnt = drawWait();
    else if (gotAck)
    begin
      if (doWrite)
        mem[wIdx] = wData;
      // Next transfer gets its own wait count
      waitCnt = drawWait();
    end
    else if (busy)
      waitCnt = waitCnt - 1;
  end

endmodule

// File: verification/armPipeTb.sv
`include "armPipe_config.svh"

module armPipeTb;
  import armPipePkg::*;

  localparam int MEM_WORDS = 256;
  localparam int TOTAL_STORES = 11;
  localparam int WAIT_LIMIT = 400;
  localparam logic [3:0] OP_AND = 4'h0;
  localparam logic [3:0] OP_SUB = 4'h2;
  localparam logic [3:0] OP_ADD = 4'h4;
  localparam logic [3:0] OP_ORR = 4'hC;
  localparam logic [3:0] OP_MOV = 4'hD;

  logic clk, rstN, iCyc, iStb, iAck, dCyc, dStb, dWe, dAck;
  word_t iAdr, iDatI, dAdr, dDatO, dDatI;
  logic [1:0] maxWait;
  word_t prog [$];
  int storeIdx, errorCount, testsOk;
  logic aborted, randomPhase;
  logic [63:0] expectedStore;

  // Running store count at the end of each section of the program
  int testEnd [0:3] = '{1, 6, 9, 11};
  string testName [0:3] = '{"reset", "forwarding", "loadUse", "branch"};

  armPipeTop DUT (.*);

  wbMemModel #(.WORDS(MEM_WORDS), .SEED(1)) instMem (
    .clk (clk), .rstN (rstN), .cyc (iCyc), .stb (iStb), .we (1'b0),
    .adr (iAdr), .datI ('0), .maxWait (maxWait), .datO (iDatI), .ack (iAck)
  );

  wbMemModel #(.WORDS(MEM_WORDS), .SEED(1)) dataMem (
    .clk (clk), .rstN (rstN), .cyc (dCyc), .stb (dStb), .we (dWe),
    .adr (dAdr), .datI (dDatO), .maxWait (maxWait), .datO (dDatI), .ack (dAck)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // ARM encodings, condition always, no S bit
  function automatic word_t dataProcImm(input logic [3:0] op, input regAddr_t rd, rn,
                                        input logic [7:0] imm);
    return {4'hE, 3'b001, op, 1'b0, rn, rd, 4'h0, imm};
  endfunction

  function automatic word_t dataProcReg(input logic [3:0] op, input regAddr_t rd, rn, rm);
    return {4'hE, 3'b000, op, 1'b0, rn, rd, 8'h00, rm};
  endfunction

  // Pre-indexed, offset added, word access
  function automatic word_t loadStore(input logic load, input regAddr_t rd, rn,
                                      input logic [11:0] off);
    return {4'hE, 3'b010, 4'b1100, load, rn, rd, off};
  endfunction

  function automatic word_t branchWord(input logic [23:0] offWords);
    return {4'hE, 4'b1010, offWords};
  endfunction

  function automatic word_t fillWord(input int idx);
    return (word_t'(idx) * 32'h9E37_79B9) ^ 32'hC0DE_0000;
  endfunction

  // Program at the bottom, address-dependent pattern everywhere else
  function automatic word_t initWord(input int idx);
    return (idx < prog.size()) ? prog[idx] : fillWord(idx);
  endfunction

  // Instruction-set model, returns address and data of store number n
  function automatic logic [63:0] refStore(input int n);
    word_t regs [0:15];
    word_t dmem [0:MEM_WORDS-1];
    word_t pc, ins, addr, opB, res;
    logic [63:0] found;
    int count, step, i;
    for (i = 0; i < MEM_WORDS; i++)
      dmem[i] = initWord(i);
    for (i = 0; i < 16; i++)
      regs[i] = '0;
    pc = `RESET_VECTOR;
    count = 0;
    found = '0;
    for (step = 0; step < 2000 && count <= n; step++)
    begin
      ins = initWord(int'(pc[9:2]));
      if (ins[27:25] == 3'b101)
        // Target is branch address plus 8 plus the word offset
        pc = pc + 8 + {{6{ins[23]}}, ins[23:0], 2'b00};
      else
      begin
        if (ins[27:26] == 2'b01)
        begin
          addr = regs[ins[19:16]] + {20'h0, ins[11:0]};
          if (ins[20])
            regs[ins[15:12]] = dmem[addr[9:2]];
          else
          begin
            if (count == n)
              found = {addr, regs[ins[15:12]]};
            dmem[addr[9:2]] = regs[ins[15:12]];
            count++;
          end
        end
        else
        begin
          opB = ins[25] ? {24'h0, ins[7:0]} : regs[ins[3:0]];
          case (ins[24:21])
            OP_SUB:  res = regs[ins[19:16]] - opB;
            OP_AND:  res = regs[ins[19:16]] & opB;
            OP_ORR:  res = regs[ins[19:16]] | opB;
            OP_MOV:  res = opB;
            default: res = regs[ins[19:16]] + opB;
          endcase
          regs[ins[15:12]] = res;
        end
        pc = pc + 4;
      end
    end
    return found;
  endfunction

  task automatic buildProgram();
    prog.delete();
    // Base register r0 and the first store
    prog.push_back(dataProcImm(OP_MOV, 0, 0, 8'h00));
    prog.push_back(dataProcImm(OP_MOV, 1, 0, 8'h11));
    prog.push_back(loadStore(1'b0, 1, 0, 12'h200));
    // Dependent chain, forwarding on A and B from memory and writeback
    prog.push_back(dataProcImm(OP_MOV, 2, 0, 8'h5A));
    prog.push_back(dataProcImm(OP_ADD, 3, 2, 8'h33));
    prog.push_back(dataProcReg(OP_ADD, 4, 2, 3));
    prog.push_back(dataProcReg(OP_SUB, 5, 4, 2));
    prog.push_back(dataProcReg(OP_AND, 7, 5, 4));
    prog.push_back(dataProcReg(OP_SUB, 8, 4, 7));
    prog.push_back(dataProcReg(OP_ORR, 9, 8, 2));
    prog.push_back(dataProcReg(OP_MOV, 10, 0, 9));
    prog.push_back(loadStore(1'b0, 10, 0, 12'h204));
    prog.push_back(loadStore(1'b0, 3, 0, 12'h208));
    prog.push_back(loadStore(1'b0, 4, 0, 12'h20C));
    prog.push_back(loadStore(1'b0, 7, 0, 12'h210));
    prog.push_back(loadStore(1'b0, 8, 0, 12'h214));
    // Loads used by the very next instruction
    prog.push_back(loadStore(1'b1, 1, 0, 12'h300));
    prog.push_back(dataProcImm(OP_ADD, 2, 1, 8'h01));
    prog.push_back(loadStore(1'b1, 3, 0, 12'h208));
    prog.push_back(dataProcReg(OP_SUB, 4, 2, 3));
    prog.push_back(loadStore(1'b1, 5, 0, 12'h304));
    prog.push_back(loadStore(1'b0, 5, 0, 12'h220));
    prog.push_back(loadStore(1'b0, 2, 0, 12'h224));
    prog.push_back(loadStore(1'b0, 4, 0, 12'h228));
    // Branch over two stores that must never reach the bus
    prog.push_back(dataProcImm(OP_MOV, 6, 0, 8'h44));
    prog.push_back(branchWord(24'h000001));
    prog.push_back(loadStore(1'b0, 6, 0, 12'h230));
    prog.push_back(loadStore(1'b0, 6, 0, 12'h234));
    prog.push_back(dataProcImm(OP_ADD, 6, 6, 8'h01));
    prog.push_back(loadStore(1'b0, 6, 0, 12'h238));
    prog.push_back(loadStore(1'b0, 1, 0, 12'h23C));
    // Park on a branch to itself
    prog.push_back(branchWord(24'hFFFFFE));
  endtask

  task automatic applyReset();
    int i;
    @(posedge clk);
    #1 rstN = 1'b0;
    for (i = 0; i < MEM_WORDS; i++)
    begin
      instMem.mem[i] = initWord(i);
      dataMem.mem[i] = initWord(i);
    end
    repeat (16) @(posedge clk);
    #1 rstN = 1'b1;
  endtask

  task automatic checkValue(input string test, input string what, input word_t expected,
                            input word_t actual);
    if (expected !== actual)
    begin
      $display("MISMATCH %s %s: expected %h, actual %h", test, what, expected, actual);
      errorCount++;
    end
  endtask

  function automatic string testOf(input int idx);
    if (randomPhase)
      return "waitStates";
    for (int k = 0; k < 4; k++)
      if (idx < testEnd[k])
        return testName[k];
    return "branch";
  endfunction

  task automatic firstFetch();
    int cycles;
    cycles = 0;
    while (!iCyc && cycles < WAIT_LIMIT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!iCyc)
    begin
      $display("reset: no instruction-bus request after reset");
      aborted = 1'b1;
    end
    else
      checkValue("reset", "first fetch address", `RESET_VECTOR, iAdr);
  endtask

  task automatic waitStores(input int target, input string test);
    int cycles;
    cycles = 0;
    while (!aborted && storeIdx < target && cycles < WAIT_LIMIT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!aborted && storeIdx < target)
    begin
      $display("%s: stalled, no store arrived within %0d cycles", test, WAIT_LIMIT);
      aborted = 1'b1;
    end
  endtask

  task automatic reportTest(input string test, input int errStart);
    if (aborted || errorCount != errStart)
      $display("test %s: error, %0d mismatches", test, errorCount - errStart);
    else
    begin
      $display("test %s: ok", test);
      testsOk++;
    end
  endtask

  // Every completed data-bus transfer against the reference
  always @(posedge clk)
  begin
    if (!rstN)
      storeIdx = 0;
    else if (dCyc && dStb && dAck)
    begin
      if (!dWe && storeIdx == 0)
      begin
        $display("%s: data-bus read before the first store", testOf(storeIdx));
        errorCount++;
      end
      else if (dWe && storeIdx >= TOTAL_STORES)
      begin
        $display("%s: extra store to %h after the last one", testOf(storeIdx), dAdr);
        errorCount++;
      end
      else if (dWe)
      begin
        expectedStore = refStore(storeIdx);
        checkValue(testOf(storeIdx), "store address", expectedStore[63:32], dAdr);
        checkValue(testOf(storeIdx), "store data", expectedStore[31:0], dDatO);
      end
      if (dWe)
        storeIdx++;
    end
  end

  initial
  begin
    int k;
    int errStart;
    rstN = 1'b0;
    maxWait = 2'd0;
    errorCount = 0;
    testsOk = 0;
    aborted = 1'b0;
    randomPhase = 1'b0;
    buildProgram();
    // No wait states, dependent instructions run back to back
    applyReset();
    for (k = 0; k < 4; k++)
    begin
      errStart = errorCount;
      if (k == 0)
        firstFetch();
      waitStores(testEnd[k], testName[k]);
      if (k == 3 && !aborted)
      begin
        repeat (40) @(negedge clk);
        checkValue("branch", "store count", TOTAL_STORES, storeIdx);
      end
      reportTest(testName[k], errStart);
    end
    // Whole program again with 0 to 3 wait states on both buses
    errStart = errorCount;
    if (!aborted)
    begin
      maxWait = 2'd3;
      randomPhase = 1'b1;
      applyReset();
      for (k = 1; k <= TOTAL_STORES; k++)
        waitStores(k, "waitStates");
      if (!aborted)
      begin
        repeat (60) @(negedge clk);
        checkValue("waitStates", "store count", TOTAL_STORES, storeIdx);
      end
    end
    reportTest("waitStates", errStart);
    $display("%0d of 5 tests ok, %0d errors", testsOk, errorCount);
    if (errorCount == 0 && !aborted)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+source
source/armPipePkg.sv
source/hazard.sv
source/regFile.sv
source/decoder.sv
source/datapath.sv
source/armPipeTop.sv
verification/wbMemModel.sv
verification/armPipeTb.sv

// File: Makefile
# Verilator build and run for the pipelined core testbench

VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing
TOP        := armPipeTb
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := TESTS FAILED
PASS_MSG   := TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
